//--- verilog/intc_pkg.sv
`default_nettype none

/* Shared widths, counts and encodings of the interrupt subsystem.
   The index widths must stay in step with the source and destination counts. */
package intc_pkg;

	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;

	localparam int INTSRCCOUNT = 8;
	localparam int INTDSTCOUNT = 4;
	localparam int SRCIDXW = 3;
	localparam int DSTIDXW = 2;

	// Peripheral port operations
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi_op_e;

	// Controller commands, found in bits 1:0 of a read-write data word
	typedef enum logic [1:0] {
		CMD_ACKINT = 2'b00,
		CMD_INTDST = 2'b01,
		CMD_ENAINT = 2'b10
	} intc_cmd_e;

	localparam logic [ARCHBITSZ-1:0] RSP_INVALID = '1;
	localparam logic [ARCHBITSZ-1:0] RSP_BUSY = {{(ARCHBITSZ-1){1'b1}}, 1'b0};

endpackage

`default_nettype wire

//--- verilog/intsrc_latch.sv
`default_nettype none

/* irq_i is taken as one-cycle pulses; each pulse is held until the controller
   starts delivering that source, seen as a falling edge on its ready line. */
module intsrc_latch (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,
	input  wire logic [intc_pkg::INTSRCCOUNT-1:0] irq_i,
	input  wire logic [intc_pkg::INTSRCCOUNT-1:0] src_rdy_i,
	output logic      [intc_pkg::INTSRCCOUNT-1:0] src_rqst_o
);

	import intc_pkg::*;

	// Ready lines as seen one cycle earlier
	logic [INTSRCCOUNT-1:0] rdy_q;

	// One bit per source whose delivery has just begun
	logic [INTSRCCOUNT-1:0] rdy_fall;

	assign rdy_fall = rdy_q & ~src_rdy_i;

	// The controller idles with every ready line high
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdy_q <= '1;
		end else begin
			rdy_q <= src_rdy_i;
		end
	end

	// A new pulse is OR-ed in after the clear, so an event that lands on the
	// delivery edge is kept and shows up again once the source is ready
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			src_rqst_o <= '0;
		end else begin
			src_rqst_o <= (src_rqst_o & ~rdy_fall) | irq_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/intctrl.sv
`default_nettype none

/* Both words of the map decode to one command register and only read-write ops act.
   One source and one destination are examined per cycle, so latency follows the scan. */
module intctrl (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,

	input  wire intc_pkg::pi_op_e                pi1_op_i,
	input  wire logic [intc_pkg::ADDRBITSZ-1:0]   pi1_addr_i,
	input  wire logic [intc_pkg::ARCHBITSZ-1:0]   pi1_data_i,
	output logic      [intc_pkg::ARCHBITSZ-1:0]   pi1_data_o,
	input  wire logic [intc_pkg::ARCHBITSZ/8-1:0] pi1_sel_i,
	output logic                                 pi1_rdy_o,
	output logic      [intc_pkg::ADDRBITSZ-1:0]   pi1_mapsz_o,

	output logic      [intc_pkg::INTDSTCOUNT-1:0] intrqstdst_o,
	input  wire logic [intc_pkg::INTDSTCOUNT-1:0] intrdydst_i,
	input  wire logic [intc_pkg::INTDSTCOUNT-1:0] intbestdst_i,

	input  wire logic [intc_pkg::INTSRCCOUNT-1:0] intrqstsrc_i,
	output logic      [intc_pkg::INTSRCCOUNT-1:0] intrdysrc_o
);

	import intc_pkg::*;

	// Decoded command word
	logic                 rwop;
	intc_cmd_e            cmd;
	logic [ARCHBITSZ-4:0] src_fld;
	logic [ARCHBITSZ-3:0] dst_fld;
	logic                 src_ok;
	logic                 dst_ok;
	logic                 ack_ok;
	logic                 ack_hit;

	// Delivery state
	logic                   pending;
	logic                   sw_post;
	logic [DSTIDXW-1:0]     sw_dst;
	logic                   seeking;
	logic [SRCIDXW-1:0]     src_idx;
	logic [DSTIDXW-1:0]     dst_idx;
	logic [SRCIDXW-1:0]     src_next;
	logic [DSTIDXW-1:0]     dst_next;
	logic [INTSRCCOUNT-1:0] src_en;
	logic [INTDSTCOUNT-1:0] dst_en;
	logic                   accept;

	logic [ARCHBITSZ-1:0] rsp;

	assign pi1_rdy_o = 1'b1;
	assign pi1_mapsz_o = ADDRBITSZ'(2);

	assign rwop = (pi1_op_i == PI_RWOP);
	assign cmd = intc_cmd_e'(pi1_data_i[1:0]);

	// ENAINT and ACKINT carry their index from bit 3 up, INTDST from bit 2 up
	assign src_fld = pi1_data_i[ARCHBITSZ-1:3];
	assign dst_fld = pi1_data_i[ARCHBITSZ-1:2];
	assign src_ok = (src_fld < INTSRCCOUNT);
	assign dst_ok = (dst_fld < INTDSTCOUNT);
	assign ack_ok = (src_fld < INTDSTCOUNT);

	// A software post is still walking toward its target destination
	assign seeking = sw_post && (dst_idx != sw_dst);

	assign ack_hit = pending && !seeking && (src_fld == (ARCHBITSZ-3)'(dst_idx));

	assign src_next = (src_idx == SRCIDXW'(INTSRCCOUNT-1)) ? '0 : src_idx + 1'b1;
	assign dst_next = (dst_idx == DSTIDXW'(INTDSTCOUNT-1)) ? '0 : dst_idx + 1'b1;

	// An enabled best destination excludes all others
	assign accept = dst_en[dst_idx] &&
		((((intbestdst_i & dst_en) == '0) && intrdydst_i[dst_idx]) ||
		intbestdst_i[dst_idx]);

	always_comb begin
		for (int i = 0; i < INTDSTCOUNT; i++) begin
			intrqstdst_o[i] = pending && !seeking && (dst_idx == DSTIDXW'(i)) && dst_en[i];
		end
	end

	// The source under delivery reads as not ready until it is acknowledged
	always_comb begin
		for (int i = 0; i < INTSRCCOUNT; i++) begin
			intrdysrc_o[i] = !(pending && !sw_post && (src_idx == SRCIDXW'(i)));
		end
	end

	always_comb begin
		rsp = RSP_INVALID;
		case (cmd)
			CMD_ENAINT: begin
				if (src_ok) begin
					rsp = ARCHBITSZ'(src_fld[SRCIDXW-1:0]);
				end
			end
			CMD_INTDST: begin
				if (dst_ok) begin
					rsp = pending ? RSP_BUSY : ARCHBITSZ'(dst_fld[DSTIDXW-1:0]);
				end
			end
			CMD_ACKINT: begin
				if (!ack_hit) begin
					rsp = RSP_BUSY;
				end else if (!sw_post) begin
					rsp = ARCHBITSZ'(src_idx);
				end
			end
			default: begin
				rsp = RSP_INVALID;
			end
		endcase
	end

	// The reply holds until the next read-write command
	always_ff @(posedge clk_i) begin
		if (rwop) begin
			pi1_data_o <= rsp;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pending <= 1'b0;
			sw_post <= 1'b0;
			sw_dst <= '0;
			src_idx <= '0;
			dst_idx <= '0;
			src_en <= '0;
			dst_en <= '0;
		end else if (rwop && cmd == CMD_ENAINT) begin
			if (src_ok) begin
				src_en[src_fld[SRCIDXW-1:0]] <= pi1_data_i[2];
			end
		end else if (rwop && cmd == CMD_INTDST) begin
			if (dst_ok && !pending) begin
				pending <= 1'b1;
				sw_post <= 1'b1;
				sw_dst <= dst_fld[DSTIDXW-1:0];
			end
		end else if (rwop && cmd == CMD_ACKINT) begin
			// Any destination may update its own enable, matched or not
			if (ack_ok) begin
				dst_en[src_fld[DSTIDXW-1:0]] <= pi1_data_i[2];
			end
			if (ack_hit) begin
				pending <= 1'b0;
				sw_post <= 1'b0;
				dst_idx <= '0;
				src_idx <= src_next;
			end
		end else if (pending) begin
			if (seeking) begin
				dst_idx <= dst_next;
			end
		end else if (src_en[src_idx] && intrqstsrc_i[src_idx]) begin
			if (accept) begin
				pending <= 1'b1;
			end else begin
				dst_idx <= dst_next;
			end
		end else begin
			src_idx <= src_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/intdst_arb.sv
`default_nettype none

/* Suggests one ready destination per cycle and moves past each destination
   that has just been given an interrupt. intrqst_i is expected one-hot or zero. */
module intdst_arb (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,
	input  wire logic [intc_pkg::INTDSTCOUNT-1:0] intrdy_i,
	input  wire logic [intc_pkg::INTDSTCOUNT-1:0] intrqst_i,
	output logic      [intc_pkg::INTDSTCOUNT-1:0] best_dst_o
);

	import intc_pkg::*;

	logic [DSTIDXW-1:0]     ptr;
	logic [DSTIDXW-1:0]     ptr_next;
	logic [INTDSTCOUNT-1:0] rqst_q;
	logic [INTDSTCOUNT-1:0] rqst_rise;

	assign rqst_rise = intrqst_i & ~rqst_q;

	// First ready destination at or after the pointer, wrapping around
	always_comb begin
		logic        found;
		int unsigned idx;
		found = 1'b0;
		best_dst_o = '0;
		for (int k = 0; k < INTDSTCOUNT; k++) begin
			idx = (int'(ptr) + k) % INTDSTCOUNT;
			if (!found && intrdy_i[idx]) begin
				best_dst_o[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		ptr_next = ptr;
		for (int i = 0; i < INTDSTCOUNT; i++) begin
			if (rqst_rise[i]) begin
				ptr_next = (i == INTDSTCOUNT-1) ? '0 : DSTIDXW'(i + 1);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ptr <= '0;
			rqst_q <= '0;
		end else begin
			ptr <= ptr_next;
			rqst_q <= intrqst_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/intc_top.sv
`default_nettype none

/* Interrupt subsystem of 8 sources and 4 destinations behind a 2-word command port.
   irq_i takes one-cycle pulses and intrdy_i is a level per core. */
module intc_top (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,

	input  wire intc_pkg::pi_op_e                pi1_op_i,
	input  wire logic [intc_pkg::ADDRBITSZ-1:0]   pi1_addr_i,
	input  wire logic [intc_pkg::ARCHBITSZ-1:0]   pi1_data_i,
	input  wire logic [intc_pkg::ARCHBITSZ/8-1:0] pi1_sel_i,
	output logic      [intc_pkg::ARCHBITSZ-1:0]   pi1_data_o,
	output logic                                 pi1_rdy_o,
	output logic      [intc_pkg::ADDRBITSZ-1:0]   pi1_mapsz_o,

	input  wire logic [intc_pkg::INTSRCCOUNT-1:0] irq_i,
	input  wire logic [intc_pkg::INTDSTCOUNT-1:0] intrdy_i,
	output logic      [intc_pkg::INTDSTCOUNT-1:0] intrqst_o
);

	import intc_pkg::*;

	logic [INTSRCCOUNT-1:0] src_rqst;
	logic [INTSRCCOUNT-1:0] src_rdy;
	logic [INTDSTCOUNT-1:0] best_dst;

	intsrc_latch u_latch (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.irq_i      (irq_i),
		.src_rdy_i  (src_rdy),
		.src_rqst_o (src_rqst)
	);

	intctrl u_ctrl (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pi1_op_i     (pi1_op_i),
		.pi1_addr_i   (pi1_addr_i),
		.pi1_data_i   (pi1_data_i),
		.pi1_data_o   (pi1_data_o),
		.pi1_sel_i    (pi1_sel_i),
		.pi1_rdy_o    (pi1_rdy_o),
		.pi1_mapsz_o  (pi1_mapsz_o),
		.intrqstdst_o (intrqst_o),
		.intrdydst_i  (intrdy_i),
		.intbestdst_i (best_dst),
		.intrqstsrc_i (src_rqst),
		.intrdysrc_o  (src_rdy)
	);

	// The arbiter watches the request lines to rotate after every delivery
	intdst_arb u_arb (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.intrdy_i   (intrdy_i),
		.intrqst_i  (intrqst_o),
		.best_dst_o (best_dst)
	);

endmodule

`default_nettype wire

//--- sim/intc_checker.sv
`default_nettype none

/* Bound into intctrl and reads its dst_en register directly.
   fail_cnt holds the number of failed checks so far. */
module intc_checker (
	input wire logic                            clk_i,
	input wire logic                            rst_i,
	input wire logic [intc_pkg::INTDSTCOUNT-1:0] rqst_i,
	input wire logic [intc_pkg::INTDSTCOUNT-1:0] dst_en_i,
	input wire logic                            rdy_i
);

	int fail_cnt = 0;

	a_rqst_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(rqst_i))
	else begin
		fail_cnt++;
		$error("Interrupt request lines are not one-hot or zero");
	end

	// Requests must be clear on the first cycle out of reset
	a_rqst_reset: assert property (@(posedge clk_i) rst_i |=> (rqst_i == '0))
	else begin
		fail_cnt++;
		$error("Interrupt request lines are not zero after reset");
	end

	a_port_rdy: assert property (@(posedge clk_i) rdy_i)
	else begin
		fail_cnt++;
		$error("Peripheral port ready went low");
	end

	a_rqst_enabled: assert property (@(posedge clk_i) disable iff (rst_i)
		((rqst_i & ~dst_en_i) == '0))
	else begin
		fail_cnt++;
		$error("Interrupt request raised to a disabled destination");
	end

endmodule

bind intctrl intc_checker u_chk (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.rqst_i   (intrqstdst_o),
	.dst_en_i (dst_en),
	.rdy_i    (pi1_rdy_o)
);

`default_nettype wire

//--- sim/intc_tb.sv
`default_nettype none

/* Six directed tests with seeded random picks of sources and destinations.
   Expects the bound checker instance u_chk inside the controller. */
module intc_tb;

	import intc_pkg::*;

	localparam int LATENCY = INTSRCCOUNT * INTDSTCOUNT + 4;
	localparam int CYCLE_LIMIT = 6 * 200;

	logic                   clk_i;
	logic                   rst_i;
	pi_op_e                 op;
	logic [ADDRBITSZ-1:0]   addr;
	logic [ARCHBITSZ-1:0]   wdata;
	logic [ARCHBITSZ/8-1:0] sel;
	logic [ARCHBITSZ-1:0]   rdata;
	logic                   rdy;
	logic [ADDRBITSZ-1:0]   mapsz;
	logic [INTSRCCOUNT-1:0] irq;
	logic [INTDSTCOUNT-1:0] intrdy;
	logic [INTDSTCOUNT-1:0] intrqst;

	int err_cnt = 0;
	int test_err = 0;
	int pass_tests = 0;
	int fail_tests = 0;
	int cycles = 0;
	int r, s, t, d, e, f1, f2;
	logic [INTDSTCOUNT-1:0] both;
	logic [ARCHBITSZ-1:0]   rsp;

	intc_top dut_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (op),
		.pi1_addr_i  (addr),
		.pi1_data_i  (wdata),
		.pi1_sel_i   (sel),
		.pi1_data_o  (rdata),
		.pi1_rdy_o   (rdy),
		.pi1_mapsz_o (mapsz),
		.irq_i       (irq),
		.intrdy_i    (intrdy),
		.intrqst_o   (intrqst)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// Command words hold the index field, then the enable bit, then the opcode
	function automatic logic [ARCHBITSZ-1:0] ena_word(int src, logic en);
		return (ARCHBITSZ'(src) << 3) | (ARCHBITSZ'(en) << 2) | ARCHBITSZ'(CMD_ENAINT);
	endfunction

	function automatic logic [ARCHBITSZ-1:0] dst_word(int dst);
		return (ARCHBITSZ'(dst) << 2) | ARCHBITSZ'(CMD_INTDST);
	endfunction

	function automatic logic [ARCHBITSZ-1:0] ack_word(int dst, logic en);
		return (ARCHBITSZ'(dst) << 3) | (ARCHBITSZ'(en) << 2) | ARCHBITSZ'(CMD_ACKINT);
	endfunction

	// The arbiter picks the first ready destination at or after its pointer
	function automatic int first_ready(int start, logic [INTDSTCOUNT-1:0] mask);
		int idx;
		for (int k = 0; k < INTDSTCOUNT; k++) begin
			idx = (start + k) % INTDSTCOUNT;
			if (mask[idx]) begin
				return idx;
			end
		end
		return -1;
	endfunction

	task automatic send_cmd(input logic [ARCHBITSZ-1:0] word,
		output logic [ARCHBITSZ-1:0] reply);
		@(posedge clk_i);
		op <= PI_RWOP;
		wdata <= word;
		@(posedge clk_i);
		op <= PI_NOOP;
		@(negedge clk_i);
		reply = rdata;
	endtask

	task automatic compare_word(input string name, input logic [ARCHBITSZ-1:0] got,
		input logic [ARCHBITSZ-1:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic pulse_irq(input int src);
		@(posedge clk_i);
		irq <= INTSRCCOUNT'(1 << src);
		@(posedge clk_i);
		irq <= '0;
	endtask

	task automatic await_rqst(input logic expect_rise);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < LATENCY) begin
			@(negedge clk_i);
			seen = (intrqst != '0);
			n++;
		end
		if (expect_rise) begin
			assert (seen) else begin
				$display("No interrupt request appeared within %0d cycles", LATENCY);
				err_cnt++;
			end
		end else begin
			assert (!seen) else begin
				$display("An interrupt request appeared for a disabled source");
				err_cnt++;
			end
		end
	endtask

	task automatic close_test(input int num, input string what);
		if (err_cnt == test_err) begin
			pass_tests++;
			$display("test %0d %s: ok", num, what);
		end else begin
			fail_tests++;
			$display("test %0d %s: %0d errors", num, what, err_cnt - test_err);
		end
		test_err = err_cnt;
	endtask

	initial begin
		void'($urandom(95149));
		rst_i <= 1'b1;
		op <= PI_NOOP;
		addr <= '0;
		wdata <= '0;
		sel <= '0;
		irq <= '0;
		intrdy <= '0;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;

		r = $urandom % INTSRCCOUNT;
		send_cmd(ena_word(r, 1'b0), rsp);
		compare_word("pi1_data_o", rsp, r);
		compare_word("intrqst_o", intrqst, '0);
		compare_word("pi1_mapsz_o", mapsz, 2);
		compare_word("pi1_rdy_o", rdy, 1);
		send_cmd(ena_word(INTSRCCOUNT + $urandom % 24, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, RSP_INVALID);
		compare_word("intrqst_o", intrqst, '0);
		close_test(1, "source enable replies");

		s = $urandom % INTSRCCOUNT;
		d = $urandom % INTDSTCOUNT;
		send_cmd(ena_word(s, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, s);
		send_cmd(ack_word(d, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, RSP_BUSY);
		@(posedge clk_i);
		intrdy <= INTDSTCOUNT'(1 << d);
		pulse_irq(s);
		await_rqst(1'b1);
		compare_word("intrqst_o", intrqst, 1 << d);
		send_cmd(ack_word(d, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, s);
		compare_word("intrqst_o", intrqst, '0);
		close_test(2, "hardware delivery and ack");

		t = (s + 1 + $urandom % (INTSRCCOUNT - 1)) % INTSRCCOUNT;
		pulse_irq(t);
		await_rqst(1'b0);
		close_test(3, "disabled source");

		send_cmd(dst_word(d), rsp);
		compare_word("pi1_data_o", rsp, d);
		send_cmd(dst_word(d), rsp);
		compare_word("pi1_data_o", rsp, RSP_BUSY);
		await_rqst(1'b1);
		compare_word("intrqst_o", intrqst, 1 << d);
		send_cmd(ack_word(d, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, RSP_INVALID);
		close_test(4, "software post");

		e = (d + 1 + $urandom % (INTDSTCOUNT - 1)) % INTDSTCOUNT;
		send_cmd(dst_word(d), rsp);
		compare_word("pi1_data_o", rsp, d);
		await_rqst(1'b1);
		send_cmd(ack_word(e, 1'b0), rsp);
		compare_word("pi1_data_o", rsp, RSP_BUSY);
		compare_word("intrqst_o", intrqst, 1 << d);
		send_cmd(ack_word(d, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, RSP_INVALID);
		close_test(5, "ack without request");

		// Every delivery so far went to d, so the pointer sits just past it
		both = INTDSTCOUNT'((1 << d) | (1 << e));
		f1 = first_ready((d + 1) % INTDSTCOUNT, both);
		f2 = first_ready((f1 + 1) % INTDSTCOUNT, both);
		send_cmd(ack_word(e, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, RSP_BUSY);
		@(posedge clk_i);
		intrdy <= both;
		pulse_irq(s);
		await_rqst(1'b1);
		compare_word("intrqst_o", intrqst, 1 << f1);
		send_cmd(ack_word(f1, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, s);
		pulse_irq(s);
		await_rqst(1'b1);
		compare_word("intrqst_o", intrqst, 1 << f2);
		send_cmd(ack_word(f2, 1'b1), rsp);
		compare_word("pi1_data_o", rsp, s);
		close_test(6, "destination rotation");

		$display("%0d tests passed, %0d tests failed, %0d checker failures",
			pass_tests, fail_tests, dut_i.u_ctrl.u_chk.fail_cnt);
		if (err_cnt == 0 && dut_i.u_ctrl.u_chk.fail_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/intc_pkg.sv
verilog/intsrc_latch.sv
verilog/intctrl.sv
verilog/intdst_arb.sv
verilog/intc_top.sv
sim/intc_checker.sv
sim/intc_tb.sv

//--- Bender.yml
package:
  name: intc

sources:
  - files:
      - verilog/intc_pkg.sv
      - verilog/intsrc_latch.sv
      - verilog/intctrl.sv
      - verilog/intdst_arb.sv
      - verilog/intc_top.sv
  - target: simulation
    files:
      - sim/intc_checker.sv
      - sim/intc_tb.sv
